// File: Makefile
TOP := tb_radio

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module radio_top -f files.f

clean:
	rm -rf obj_dir sim.log

// File: files.f
radio_pkg.sv
radio_cmd_regs.sv
radio_freq_calc.sv
radio_tx_keyer.sv
radio_rx_packer.sv
radio_top.sv
tb_radio.sv

// File: radio_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module radio_cmd_regs import radio_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  wire cmd_word_u             cmd_data_i,
  input  wire logic                  cmd_rqst_i,
  output logic                       cmd_ack_o,
  output radio_cfg_t                 cfg_o,
  output freq_cmd_t                  freq_cmd_o
);

  logic [1:0] state;
  logic       is_freq_addr;

  // TX slot or one of the receiver slots starting at RX0
  assign is_freq_addr = (cmd_addr_i == CMD_ADDR_TX_FREQ) ||
                        ((cmd_addr_i >= CMD_ADDR_RX0_FREQ) &&
                         (cmd_addr_i < CMD_ADDR_RX0_FREQ + CMD_ADDR_W'(NUM_RX)));

  // ----------------------------------------------------------
  // Command FSM and control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= CMD_IDLE;
      cfg_o <= CFG_RESET;
    end else begin
      case (state)
        CMD_IDLE: begin
          if (cmd_rqst_i) begin
            if (is_freq_addr) begin
              state <= CMD_FREQ1;
            end else begin
              // Control words take effect at once with no acknowledge
              case (cmd_addr_i)
                CMD_ADDR_CTRL: begin
                  cfg_o.last_chan <= cmd_data_i.ctrl.last_chan;
                  cfg_o.duplex    <= cmd_data_i.ctrl.duplex;
                end
                CMD_ADDR_CW_HANG: begin
                  cfg_o.cw_hang_time <= {cmd_data_i.cw_hang.hang_hi,
                                         cmd_data_i.cw_hang.hang_lo};
                end
                CMD_ADDR_TX_TIMING: begin
                  cfg_o.tx_buffer_latency <= cmd_data_i.timing.latency;
                  cfg_o.ptt_hang_time     <= cmd_data_i.timing.ptt_hang;
                end
                // Unknown addresses drop silently
                default: ;
              endcase
            end
          end
        end
        // Two cycles of settling for the multiplier
        CMD_FREQ1: state <= CMD_FREQ2;
        CMD_FREQ2: state <= CMD_FREQ3;
        default:   state <= CMD_IDLE;
      endcase
    end
  end

  // Acknowledge in the third stage
  assign cmd_ack_o = (state == CMD_FREQ3);

  // Host holds address and data until the acknowledge
  assign freq_cmd_o.capture = (state == CMD_FREQ2);
  assign freq_cmd_o.commit  = (state == CMD_FREQ3);
  assign freq_cmd_o.addr    = cmd_addr_i;
  assign freq_cmd_o.data    = cmd_data_i.raw;

endmodule

`default_nettype wire

// File: radio_freq_calc.sv
`timescale 1ns/1ps
`default_nettype none

module radio_freq_calc import radio_pkg::*; (
  input  wire logic               clk,
  input  wire logic               rst_n_i,
  input  wire freq_cmd_t          freq_cmd_i,
  input  wire radio_cfg_t         cfg_i,
  output phase_t                  tx_phase_o,
  output phase_t [NUM_RX-1:0]     rx_phase_o
);

  logic [63:0]           freq_prod;
  phase_t                phase_q;
  logic [CMD_ADDR_W-1:0] addr_q;
  logic                  share_rx0;

  // Hz times 2^57 / fclk, rounded
  assign freq_prod = 64'(freq_cmd_i.data) * 64'(FREQ_M2) + 64'(FREQ_M3);

  // Simplex single receiver listens on the TX frequency
  assign share_rx0 = !cfg_i.duplex && (cfg_i.last_chan == '0);

  // Product has had two cycles to settle by the capture stage
  always_ff @(posedge clk) begin
    if (freq_cmd_i.capture) begin
      phase_q <= freq_prod[FREQ_MSB:FREQ_LSB];
      addr_q  <= freq_cmd_i.addr;
    end
  end

  // ----------------------------------------------------------
  // Phase routing on commit
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_phase_o <= '0;
      rx_phase_o <= '0;
    end else if (freq_cmd_i.commit) begin
      if (addr_q == CMD_ADDR_TX_FREQ) begin
        tx_phase_o <= phase_q;
        if (share_rx0) rx_phase_o[0] <= phase_q;
      end
      // RX0 write while shared restores the TX phase
      if (addr_q == CMD_ADDR_RX0_FREQ) begin
        rx_phase_o[0] <= share_rx0 ? tx_phase_o : phase_q;
      end
      for (int c = 1; c < NUM_RX; c++) begin
        if (addr_q == CMD_ADDR_RX0_FREQ + CMD_ADDR_W'(c)) rx_phase_o[c] <= phase_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: radio_pkg.sv
`default_nettype none

package radio_pkg;

  // ----------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------
  localparam int NUM_RX     = 3;
  localparam int RX_IDX_W   = $clog2(NUM_RX);
  localparam int CMD_ADDR_W = 6;
  localparam int PHASE_W    = 32;
  localparam int SAMPLE_W   = 24;
  localparam int TX_W       = 16;
  localparam int CHAN_W     = 5;
  // Quarter-millisecond timer holds a 5 bit setting times 4
  localparam int QMS_W      = 7;
  localparam int CW_LEVEL_W = 19;

  // Phase increment scale for a 76.8 MHz sample clock
  localparam logic [31:0] FREQ_M2  = 32'd1876499845;
  // Rounding term added before the slice
  localparam logic [31:0] FREQ_M3  = 32'd16777216;
  localparam int          FREQ_LSB = 25;
  localparam int          FREQ_MSB = 56;

  // Command addresses
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_CTRL      = 6'h00;
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_TX_FREQ   = 6'h01;
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_RX0_FREQ  = 6'h02;
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_CW_HANG   = 6'h10;
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_TX_TIMING = 6'h17;

  // CW shaping ceiling
  localparam logic [CW_LEVEL_W-1:0] MAX_CWLEVEL = 19'h4d800;

  // Command FSM, Gray coded
  localparam logic [1:0] CMD_IDLE  = 2'b00;
  localparam logic [1:0] CMD_FREQ1 = 2'b01;
  localparam logic [1:0] CMD_FREQ2 = 2'b11;
  localparam logic [1:0] CMD_FREQ3 = 2'b10;

  // Transmit run FSM
  localparam logic [2:0] TX_IDLE     = 3'b000;
  localparam logic [2:0] TX_PTT      = 3'b001;
  localparam logic [2:0] TX_PRE      = 3'b110;
  localparam logic [2:0] TX_CW       = 3'b100;
  localparam logic [2:0] TX_CW_HANG  = 3'b101;
  localparam logic [2:0] TX_CWX      = 3'b010;
  localparam logic [2:0] TX_CWX_HANG = 3'b011;

  // Upstream framer FSM
  localparam logic [1:0] RXUS_WAIT1 = 2'b00;
  localparam logic [1:0] RXUS_I     = 2'b10;
  localparam logic [1:0] RXUS_Q     = 2'b11;
  localparam logic [1:0] RXUS_WAIT0 = 2'b01;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [PHASE_W-1:0] phase_t;

  // One command data word, read through the view of its address
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [23:0] rsvd_hi;
      logic [4:0]  last_chan;
      logic        duplex;
      logic [1:0]  rsvd_lo;
    } ctrl;
    struct packed {
      logic [7:0]  hang_hi;
      logic [5:0]  rsvd_mid;
      logic [1:0]  hang_lo;
      logic [15:0] rsvd_lo;
    } cw_hang;
    struct packed {
      logic [18:0] rsvd_hi;
      logic [4:0]  ptt_hang;
      logic [2:0]  rsvd_mid;
      logic [4:0]  latency;
    } timing;
  } cmd_word_u;

  typedef struct packed {
    logic [CHAN_W-1:0] last_chan;
    logic              duplex;
    logic [9:0]        cw_hang_time;
    logic [4:0]        tx_buffer_latency;
    logic [4:0]        ptt_hang_time;
  } radio_cfg_t;

  // Latency 10 and PTT hang 4 out of reset
  localparam radio_cfg_t CFG_RESET = '{
    last_chan:         '0,
    duplex:            1'b0,
    cw_hang_time:      '0,
    tx_buffer_latency: 5'd10,
    ptt_hang_time:     5'd4
  };

  typedef struct packed {
    logic                  capture;
    logic                  commit;
    logic [CMD_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } freq_cmd_t;

  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } rx_iq_t;

  typedef struct packed {
    logic [TX_W-1:0] i;
    logic [TX_W-1:0] q;
  } tx_iq_t;

endpackage

`default_nettype wire

// File: radio_rx_packer.sv
`timescale 1ns/1ps
`default_nettype none

module radio_rx_packer import radio_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n_i,
  input  wire logic                rx_rdy_i,
  input  wire rx_iq_t [NUM_RX-1:0] rx_sample_i,
  input  wire radio_cfg_t          cfg_i,
  input  wire logic                rx_tready_i,
  output logic [SAMPLE_W-1:0]      rx_tdata_o,
  output logic                     rx_tvalid_o,
  output logic                     rx_tlast_o
);

  logic [1:0]        state;
  logic [1:0]        state_nxt;
  logic [CHAN_W-1:0] chan;
  logic [CHAN_W-1:0] chan_nxt;
  logic [CHAN_W-1:0] last;
  rx_iq_t            cur;

  // Clamp last channel to the receivers that exist
  assign last = (cfg_i.last_chan > CHAN_W'(NUM_RX - 1)) ? CHAN_W'(NUM_RX - 1)
                                                        : cfg_i.last_chan;
  assign cur  = rx_sample_i[chan[RX_IDX_W-1:0]];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= RXUS_WAIT1;
      chan  <= '0;
    end else begin
      state <= state_nxt;
      chan  <= chan_nxt;
    end
  end

  // ----------------------------------------------------------
  // Framer, one word per cycle once started
  // ----------------------------------------------------------
  always_comb begin
    state_nxt   = state;
    chan_nxt    = chan;
    rx_tdata_o  = '0;
    rx_tvalid_o = 1'b0;
    rx_tlast_o  = 1'b0;

    case (state)
      RXUS_WAIT1: begin
        chan_nxt = '0;
        // tready sampled only here
        if (rx_rdy_i && rx_tready_i) state_nxt = RXUS_I;
      end
      RXUS_I: begin
        rx_tvalid_o = 1'b1;
        rx_tdata_o  = cur.i;
        state_nxt   = RXUS_Q;
      end
      RXUS_Q: begin
        rx_tvalid_o = 1'b1;
        rx_tdata_o  = cur.q;
        if (chan == last) begin
          rx_tlast_o = 1'b1;
          state_nxt  = RXUS_WAIT0;
        end else begin
          chan_nxt  = chan + 1'b1;
          state_nxt = RXUS_I;
        end
      end
      default: begin
        // Rearm once the ready level drops
        chan_nxt = '0;
        if (!rx_rdy_i) state_nxt = RXUS_WAIT1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: radio_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_top import radio_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  // Command slave
  input  wire logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  wire cmd_word_u             cmd_data_i,
  input  wire logic                  cmd_rqst_i,
  output logic                       cmd_ack_o,
  output phase_t                     tx_phase_o,
  output phase_t [NUM_RX-1:0]        rx_phase_o,
  // Transmit keying
  input  wire logic                  run_i,
  input  wire logic                  qmsec_pulse_i,
  input  wire logic                  ext_keydown_i,
  input  wire tx_iq_t                tx_tdata_i,
  input  wire logic                  tx_tvalid_i,
  input  wire logic [3:0]            tx_tuser_i,
  input  wire logic                  tx_sample_req_i,
  output logic                       tx_tready_o,
  output logic                       tx_on_o,
  output logic                       cw_on_o,
  output tx_iq_t                     tx_iq_o,
  output logic [14:0]                tx_cw_level_o,
  // Receive upstream
  input  wire logic                  rx_rdy_i,
  input  wire rx_iq_t [NUM_RX-1:0]   rx_sample_i,
  input  wire logic                  rx_tready_i,
  output logic [SAMPLE_W-1:0]        rx_tdata_o,
  output logic                       rx_tvalid_o,
  output logic                       rx_tlast_o
);

  radio_cfg_t cfg;
  freq_cmd_t  freq_cmd;

  radio_cmd_regs u_cmd_regs (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_rqst_i (cmd_rqst_i),
    .cmd_ack_o  (cmd_ack_o),
    .cfg_o      (cfg),
    .freq_cmd_o (freq_cmd)
  );

  radio_freq_calc u_freq_calc (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .freq_cmd_i (freq_cmd),
    .cfg_i      (cfg),
    .tx_phase_o (tx_phase_o),
    .rx_phase_o (rx_phase_o)
  );

  radio_tx_keyer u_tx_keyer (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .run_i           (run_i),
    .qmsec_pulse_i   (qmsec_pulse_i),
    .ext_keydown_i   (ext_keydown_i),
    .tx_tdata_i      (tx_tdata_i),
    .tx_tvalid_i     (tx_tvalid_i),
    .tx_tuser_i      (tx_tuser_i),
    .tx_sample_req_i (tx_sample_req_i),
    .cfg_i           (cfg),
    .tx_tready_o     (tx_tready_o),
    .tx_on_o         (tx_on_o),
    .cw_on_o         (cw_on_o),
    .tx_iq_o         (tx_iq_o),
    .tx_cw_level_o   (tx_cw_level_o)
  );

  radio_rx_packer u_rx_packer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_rdy_i    (rx_rdy_i),
    .rx_sample_i (rx_sample_i),
    .cfg_i       (cfg),
    .rx_tready_i (rx_tready_i),
    .rx_tdata_o  (rx_tdata_o),
    .rx_tvalid_o (rx_tvalid_o),
    .rx_tlast_o  (rx_tlast_o)
  );

endmodule

`default_nettype wire

// File: radio_tx_keyer.sv
`timescale 1ns/1ps
`default_nettype none

module radio_tx_keyer import radio_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n_i,
  input  wire logic        run_i,
  input  wire logic        qmsec_pulse_i,
  input  wire logic        ext_keydown_i,
  input  wire tx_iq_t      tx_tdata_i,
  input  wire logic        tx_tvalid_i,
  input  wire logic [3:0]  tx_tuser_i,
  input  wire logic        tx_sample_req_i,
  input  wire radio_cfg_t  cfg_i,
  output logic             tx_tready_o,
  output logic             tx_on_o,
  output logic             cw_on_o,
  output tx_iq_t           tx_iq_o,
  output logic [14:0]      tx_cw_level_o
);

  logic [2:0]            state;
  logic [2:0]            state_nxt;
  logic [QMS_W-1:0]      timer;
  logic [QMS_W-1:0]      timer_nxt;
  logic [CW_LEVEL_W-1:0] level;
  logic [CW_LEVEL_W-1:0] level_nxt;
  tx_iq_t                iq_nxt;
  logic                  ptt;
  logic                  cwx;
  logic                  any_key;
  logic [QMS_W-1:0]      lat_load;
  logic [QMS_W-1:0]      ptt_load;
  logic [CW_LEVEL_W-1:0] hang_load;

  // Keying flags from the downstream user bits
  assign ptt     = tx_tuser_i[3] & tx_tvalid_i;
  assign cwx     = tx_tuser_i[2] & tx_tvalid_i;
  assign any_key = ext_keydown_i | cwx | ptt;

  // Settings count in milliseconds, timers in quarter steps
  assign lat_load  = {cfg_i.tx_buffer_latency, 2'b00};
  assign ptt_load  = {cfg_i.ptt_hang_time, 2'b00};
  assign hang_load = CW_LEVEL_W'({cfg_i.cw_hang_time, 2'b00});

  // Top bits of the level drive the CW amplitude
  assign tx_cw_level_o = level[18:4];

  // ----------------------------------------------------------
  // Run FSM registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state   <= TX_IDLE;
      timer   <= '0;
      level   <= '0;
      tx_iq_o <= '0;
    end else begin
      // Dropping run forces idle
      state   <= run_i ? state_nxt : TX_IDLE;
      timer   <= timer_nxt;
      level   <= level_nxt;
      tx_iq_o <= iq_nxt;
    end
  end

  always_comb begin
    state_nxt   = state;
    timer_nxt   = timer;
    level_nxt   = level;
    iq_nxt      = tx_iq_o;
    tx_on_o     = 1'b1;
    cw_on_o     = 1'b0;
    tx_tready_o = tx_sample_req_i;

    case (state)
      TX_IDLE: begin
        tx_on_o     = 1'b0;
        tx_tready_o = 1'b0;
        iq_nxt      = '0;
        level_nxt   = '0;
        timer_nxt   = lat_load;
        if (any_key) state_nxt = TX_PRE;
      end

      // Stall the sample stream while the buffer fills
      TX_PRE: begin
        tx_tready_o = 1'b0;
        if (timer != '0) begin
          if (qmsec_pulse_i) timer_nxt = timer - 1'b1;
          if (!any_key) state_nxt = TX_IDLE;
        end else if (ptt) begin
          state_nxt = TX_PTT;
        end else if (ext_keydown_i) begin
          state_nxt = TX_CW;
        end else begin
          state_nxt = TX_CWX;
        end
      end

      TX_PTT: begin
        if (ptt) begin
          timer_nxt = ptt_load;
          if (tx_sample_req_i) iq_nxt = tx_tdata_i;
        end else if (timer != '0) begin
          // PTT hang
          if (qmsec_pulse_i) timer_nxt = timer - 1'b1;
        end else begin
          state_nxt = TX_IDLE;
        end
      end

      TX_CW: begin
        cw_on_o = 1'b1;
        if (ext_keydown_i) begin
          // Ramp up
          if (level != MAX_CWLEVEL) level_nxt = level + 1'b1;
          timer_nxt = lat_load;
        end else if (timer != '0) begin
          // hold the key for the buffer latency
          if (qmsec_pulse_i) timer_nxt = timer - 1'b1;
        end else if (level != '0) begin
          level_nxt = level - 1'b1;
        end else begin
          timer_nxt = lat_load;
          level_nxt = hang_load;
          state_nxt = TX_CW_HANG;
        end
      end

      // Level register doubles as the hang counter
      TX_CW_HANG: begin
        cw_on_o = 1'b1;
        if (ext_keydown_i) begin
          if (timer != '0) begin
            if (qmsec_pulse_i) timer_nxt = timer - 1'b1;
          end else begin
            timer_nxt = lat_load;
            level_nxt = '0;
            state_nxt = TX_CW;
          end
        end else if (level != '0) begin
          if (qmsec_pulse_i) level_nxt = level - 1'b1;
        end else begin
          state_nxt = TX_IDLE;
        end
      end

      TX_CWX: begin
        cw_on_o = 1'b1;
        if (cwx) begin
          if (level != MAX_CWLEVEL) level_nxt = level + 1'b1;
        end else if (level != '0) begin
          level_nxt = level - 1'b1;
        end else begin
          level_nxt = hang_load;
          state_nxt = TX_CWX_HANG;
        end
      end

      TX_CWX_HANG: begin
        cw_on_o = 1'b1;
        if (cwx) begin
          state_nxt = TX_CWX;
        end else if (level != '0) begin
          if (qmsec_pulse_i) level_nxt = level - 1'b1;
        end else begin
          state_nxt = TX_IDLE;
        end
      end

      default: state_nxt = TX_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: tb_radio.sv
`timescale 1ns/1ps
`default_nettype none

module tb_radio import radio_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int QMS_PERIOD   = 8;
  localparam int NROWS        = 10;
  // CW level ceiling, 19 bits
  localparam logic [18:0] CW_CEIL = 19'h4d800;
  // Pre-TX and hang waits at the largest settings, plus one full CW ramp
  localparam int KEY_CYCLES      = 2 * (4 * 32 * QMS_PERIOD) + int'(CW_CEIL) + 400;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NROWS * 10 + 100 + KEY_CYCLES;

  localparam logic [2:0] TGT_TX   = 3'd0;
  localparam logic [2:0] TGT_NONE = 3'd7;

  // One command row; tgt is 0 for the TX phase, c+1 for receiver c
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [31:0]           data;
    logic                  ack;
    logic [2:0]            tgt;
  } cmd_row_t;

  logic                  clk = 1'b0;
  logic                  rst_n_i;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  cmd_word_u             cmd_data_i;
  logic                  cmd_rqst_i;
  logic                  cmd_ack_o;
  phase_t                tx_phase_o;
  phase_t [NUM_RX-1:0]   rx_phase_o;
  logic                  run_i;
  logic                  qmsec_pulse_i = 1'b0;
  logic                  ext_keydown_i;
  tx_iq_t                tx_tdata_i;
  logic                  tx_tvalid_i;
  logic [3:0]            tx_tuser_i;
  logic                  tx_sample_req_i;
  logic                  tx_tready_o;
  logic                  tx_on_o;
  logic                  cw_on_o;
  tx_iq_t                tx_iq_o;
  logic [14:0]           tx_cw_level_o;
  logic                  rx_rdy_i;
  rx_iq_t [NUM_RX-1:0]   rx_sample_i;
  logic                  rx_tready_i;
  logic [SAMPLE_W-1:0]   rx_tdata_o;
  logic                  rx_tvalid_o;
  logic                  rx_tlast_o;

  cmd_row_t    rows [NROWS];
  int          qms_div   = 0;
  int          pulse_cnt = 0;

  // Reference model of the phase outputs and config
  logic [31:0] exp_tx;
  logic [31:0] exp_rx [NUM_RX];
  logic        m_dup;
  logic [4:0]  m_last;
  logic [4:0]  m_lat;
  logic [4:0]  m_ptt;

  radio_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Quarter-millisecond strobe, one cycle in every QMS_PERIOD
  always @(negedge clk) begin
    if (qms_div == QMS_PERIOD - 1) begin
      qms_div       = 0;
      qmsec_pulse_i = 1'b1;
    end else begin
      qms_div       = qms_div + 1;
      qmsec_pulse_i = 1'b0;
    end
  end

  // Pulses as the DUT sees them
  always @(posedge clk) begin
    if (qmsec_pulse_i) pulse_cnt <= pulse_cnt + 1;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired before the test sequence finished");
    stop_failed();
  end

  // ----------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------
  task automatic stop_failed();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic timed_out(input string what);
    $display("ERROR: timed out waiting for %s", what);
    stop_failed();
  endtask

  // Hz to phase increment, rounded, bits 56:25 of the product
  function automatic logic [31:0] phase_of(input logic [31:0] hz);
    logic [63:0] prod;
    prod = 64'(hz) * 64'd1876499845 + 64'd16777216;
    return prod[56:25];
  endfunction

  function automatic logic [31:0] model_target(input logic [2:0] tgt);
    return (tgt == TGT_TX) ? exp_tx : exp_rx[tgt - 1];
  endfunction

  function automatic logic [31:0] dut_target(input logic [2:0] tgt);
    return (tgt == TGT_TX) ? tx_phase_o : rx_phase_o[tgt - 1];
  endfunction

  function automatic logic [23:0] sample_i(input int c);
    return 24'hc00000 + 24'(c) * 24'h010101;
  endfunction

  function automatic logic [23:0] sample_q(input int c);
    return 24'h300000 + 24'(c) * 24'h010101;
  endfunction

  task automatic check_phases(input string tag);
    check_eq({tag, " tx_phase"}, exp_tx, tx_phase_o);
    for (int c = 0; c < NUM_RX; c++) begin
      check_eq($sformatf("%s rx%0d_phase", tag, c), exp_rx[c], rx_phase_o[c]);
    end
  endtask

  // Routing rule of the command slave
  task automatic model_apply(input cmd_row_t r);
    logic [31:0] p;
    p = phase_of(r.data);
    case (r.addr)
      6'h00: begin
        m_last = r.data[7:3];
        m_dup  = r.data[2];
      end
      6'h17: begin
        m_lat = r.data[4:0];
        m_ptt = r.data[12:8];
      end
      6'h01: begin
        exp_tx = p;
        if (!m_dup && m_last == 5'd0) exp_rx[0] = p;
      end
      6'h02: exp_rx[0] = (!m_dup && m_last == 5'd0) ? exp_tx : p;
      6'h03, 6'h04: exp_rx[r.addr - 6'd2] = p;
      default: ;
    endcase
  endtask

  // ----------------------------------------------------------
  // Command table
  // ----------------------------------------------------------
  task automatic fill_table();
    rows[0] = '{6'h01, $urandom(), 1'b1, TGT_TX};
    rows[1] = '{6'h03, $urandom(), 1'b1, 3'd2};
    rows[2] = '{6'h04, $urandom(), 1'b1, 3'd3};
    // Simplex, one receiver: RX0 follows TX
    rows[3] = '{6'h02, $urandom(), 1'b1, 3'd1};
    // Duplex on, last channel 0
    rows[4] = '{6'h00, 32'h0000_0004, 1'b0, TGT_NONE};
    rows[5] = '{6'h02, $urandom(), 1'b1, 3'd1};
    rows[6] = '{6'h01, $urandom(), 1'b1, TGT_TX};
    // Simplex, last channel 2
    rows[7] = '{6'h00, 32'h0000_0010, 1'b0, TGT_NONE};
    // Latency 2, PTT hang 1
    rows[8] = '{6'h17, 32'h0000_0102, 1'b0, TGT_NONE};
    rows[9] = '{6'h3f, $urandom(), 1'b0, TGT_NONE};
  endtask

  task automatic run_row(input int idx);
    cmd_row_t r;
    string    tag;
    int       n;
    r   = rows[idx];
    tag = $sformatf("row%0d addr 0x%0h", idx, r.addr);
    @(negedge clk);
    cmd_addr_i     = r.addr;
    cmd_data_i.raw = r.data;
    cmd_rqst_i     = 1'b1;
    @(negedge clk);
    cmd_rqst_i = 1'b0;
    n = 1;
    if (r.ack) begin
      while (!cmd_ack_o) begin
        if (n == 8) timed_out({tag, " acknowledge"});
        @(negedge clk);
        n++;
      end
      check_eq({tag, " ack latency"}, 3, n);
      @(negedge clk);
      check_eq({tag, " ack width"}, 0, cmd_ack_o);
    end else begin
      repeat (4) begin
        check_eq({tag, " no ack"}, 0, cmd_ack_o);
        @(negedge clk);
      end
    end
    model_apply(r);
    if (r.tgt != TGT_NONE) begin
      check_eq({tag, " target phase"}, model_target(r.tgt), dut_target(r.tgt));
    end
    check_phases(tag);
  endtask

  // ----------------------------------------------------------
  // Receive framing
  // ----------------------------------------------------------
  task automatic check_packer();
    int n;
    @(negedge clk);
    for (int c = 0; c < NUM_RX; c++) begin
      rx_sample_i[c].i = sample_i(c);
      rx_sample_i[c].q = sample_q(c);
    end
    rx_tready_i = 1'b1;
    rx_rdy_i    = 1'b1;
    n = 0;
    while (!rx_tvalid_o) begin
      if (n == 8) timed_out("first upstream word");
      @(negedge clk);
      n++;
    end
    // I then Q for channels 0 to last
    for (int k = 0; k < 2 * (int'(m_last) + 1); k++) begin
      check_eq($sformatf("frame word%0d valid", k), 1, rx_tvalid_o);
      check_eq($sformatf("frame word%0d data", k),
               (k % 2 == 0) ? sample_i(k / 2) : sample_q(k / 2), rx_tdata_o);
      check_eq($sformatf("frame word%0d last", k), (k == 2 * int'(m_last) + 1), rx_tlast_o);
      @(negedge clk);
    end
    // Ready still high, so no new frame yet
    repeat (4) begin
      check_eq("no rearm valid", 0, rx_tvalid_o);
      @(negedge clk);
    end
    rx_rdy_i = 1'b0;
    @(negedge clk);
    rx_rdy_i = 1'b1;
    n = 0;
    while (!rx_tvalid_o) begin
      if (n == 8) timed_out("second frame after rearm");
      @(negedge clk);
      n++;
    end
    check_eq("rearm word0 data", sample_i(0), rx_tdata_o);
    rx_rdy_i = 1'b0;
  endtask

  // ----------------------------------------------------------
  // PTT keying
  // ----------------------------------------------------------
  task automatic check_ptt();
    int     n;
    int     start;
    tx_iq_t word;
    word = '{i: 16'h1357, q: 16'h9bdf};
    @(negedge clk);
    run_i           = 1'b1;
    tx_tdata_i      = word;
    tx_tvalid_i     = 1'b1;
    tx_tuser_i      = 4'b1000;
    tx_sample_req_i = 1'b1;
    start = pulse_cnt;
    @(negedge clk);
    n = 1;
    while (!tx_tready_o) begin
      check_eq("pre-tx tx_on", 1, tx_on_o);
      if (n == (4 * int'(m_lat) + 2) * QMS_PERIOD + 8) timed_out("tready after pre-TX");
      @(negedge clk);
      n++;
    end
    check_eq("pre-tx pulses reached", 1, (pulse_cnt - start) >= 4 * int'(m_lat));
    @(negedge clk);
    check_eq("ptt tx_iq", word, tx_iq_o);
    // Back-pressure from the interpolator
    tx_sample_req_i = 1'b0;
    tx_tdata_i      = '{i: 16'h2468, q: 16'hace0};
    @(negedge clk);
    check_eq("ptt tready follows req", 0, tx_tready_o);
    check_eq("ptt tx_iq held", word, tx_iq_o);
    tx_tvalid_i = 1'b0;
    tx_tuser_i  = 4'b0000;
    start = pulse_cnt;
    n = 0;
    while (tx_on_o) begin
      if (n == (4 * int'(m_ptt) + 2) * QMS_PERIOD + 8) timed_out("tx_on to fall after hang");
      @(negedge clk);
      n++;
    end
    check_eq("ptt hang pulses reached", 1, (pulse_cnt - start) >= 4 * int'(m_ptt));
    @(negedge clk);
    check_eq("idle tx_iq cleared", 0, tx_iq_o);
  endtask

  // ----------------------------------------------------------
  // CW keying and run drop
  // ----------------------------------------------------------
  task automatic check_cw();
    int n;
    @(negedge clk);
    ext_keydown_i = 1'b1;
    n = 0;
    while (!cw_on_o) begin
      if (n == (4 * int'(m_lat) + 2) * QMS_PERIOD + 8) timed_out("cw_on after pre-TX");
      @(negedge clk);
      n++;
    end
    n = 0;
    while (tx_cw_level_o != CW_CEIL[18:4]) begin
      if (n == int'(CW_CEIL) + 16) timed_out("CW level to reach its ceiling");
      @(negedge clk);
      n++;
    end
    repeat (16) @(negedge clk);
    check_eq("cw level saturated", CW_CEIL[18:4], tx_cw_level_o);
    check_eq("cw_on while keyed", 1, cw_on_o);
    run_i = 1'b0;
    @(negedge clk);
    check_eq("run low tx_on", 0, tx_on_o);
    check_eq("run low cw_on", 0, cw_on_o);
    ext_keydown_i = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(4));
    rst_n_i         = 1'b0;
    cmd_addr_i      = '0;
    cmd_data_i      = '0;
    cmd_rqst_i      = 1'b0;
    run_i           = 1'b0;
    ext_keydown_i   = 1'b0;
    tx_tdata_i      = '0;
    tx_tvalid_i     = 1'b0;
    tx_tuser_i      = '0;
    tx_sample_req_i = 1'b0;
    rx_rdy_i        = 1'b0;
    rx_sample_i     = '0;
    rx_tready_i     = 1'b0;
    // Model starts from the reset config
    exp_tx = '0;
    for (int c = 0; c < NUM_RX; c++) exp_rx[c] = '0;
    m_dup  = 1'b0;
    m_last = 5'd0;
    m_lat  = 5'd10;
    m_ptt  = 5'd4;
    fill_table();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    check_eq("reset tx_on", 0, tx_on_o);
    check_eq("reset cw_on", 0, cw_on_o);
    check_eq("reset tx_tready", 0, tx_tready_o);
    check_eq("reset rx_tvalid", 0, rx_tvalid_o);
    check_eq("reset rx_tlast", 0, rx_tlast_o);
    check_eq("reset cmd_ack", 0, cmd_ack_o);
    check_phases("reset");

    for (int i = 0; i < NROWS; i++) run_row(i);
    check_packer();
    check_ptt();
    check_cw();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
